/* gb_settings.svh */
// ------------------------------------------------
// memory map, widths, serial timing and irq vectors
// included by the package and by every module using them
// ------------------------------------------------
`ifndef GB_SETTINGS_SVH
`define GB_SETTINGS_SVH

`define GB_ADDR_W        16      // cpu address bus
`define GB_DATA_W        8       // cpu data bus
`define GB_ZPRAM_AW      7       // 127 bytes at ff80
`define GB_WRAM_AW       15      // 8 banks of 4k
`define GB_WRAM_BANK_W   3       // svbk bank select

// register addresses
`define GB_ADDR_P1       16'hff00
`define GB_ADDR_SB       16'hff01
`define GB_ADDR_SC       16'hff02
`define GB_ADDR_IF       16'hff0f
`define GB_ADDR_SVBK     16'hff70
`define GB_ADDR_IE       16'hffff

`define GB_IRQ_N         5       // vblank, lcd, timer, serial, joypad
`define GB_SERIAL_DIV    512     // 8192 Hz bit clock
`define GB_SERIAL_BITS   8
`define GB_IRQ_VEC_BASE  8'h40
`define GB_IRQ_VEC_STEP  8
`define GB_IRQ_VEC_NONE  8'h55   // nothing pending
`define GB_OPEN_BUS      8'hff   // unmapped reads

`endif

/* gb_pkg.sv */
// ------------------------------------------------
// bus types, decoded regions and interrupt bit positions
// ------------------------------------------------
`include "gb_settings.svh"

package gb_pkg;

	typedef logic [`GB_ADDR_W-1:0] addr_t;   // cpu address
	typedef logic [`GB_DATA_W-1:0] data_t;   // one bus byte
	typedef logic [`GB_IRQ_N-1:0]  irq_t;    // one bit per source

	// target of the current cpu access
	typedef enum logic [3:0] {
		REG_ROM,     // 0000-7fff cartridge rom
		REG_CRAM,    // a000-bfff cartridge ram
		REG_WRAM,    // c000-fdff incl echo
		REG_ZPRAM,   // ff80-fffe
		REG_JOY,     // p1
		REG_SB,      // serial data, read only
		REG_SC,      // serial control
		REG_IF,
		REG_IE,
		REG_SVBK,    // wram bank, colour mode
		REG_NONE     // open bus
	} region_e;

	// flag positions in IF and IE, lowest index wins
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCD    = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} irq_bit_e;

endpackage

/* gb_spram.sv */
// ------------------------------------------------
// byte wide single port ram, registered read
// ------------------------------------------------
`timescale 1ns/10ps

module gb_spram #(
	parameter int addr_w = 7
) (
	input  logic              clk_cpu,
	input  logic [addr_w-1:0] addr,
	input  logic              we,
	input  gb_pkg::data_t     wdata,
	output gb_pkg::data_t     rdata
);

	gb_pkg::data_t mem [0:(1<<addr_w)-1];

	always_ff @(posedge clk_cpu) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= we ? wdata : mem[addr];   // write-first
	end

endmodule

/* gb_bus_decode.sv */
// ------------------------------------------------
// cpu address decode, write strobe gating and read mux
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_settings.svh"

module gb_bus_decode (
	input  gb_pkg::addr_t cpu_addr,
	input  logic          cpu_rd,
	input  logic          cpu_wr,
	input  logic          cpu_ack,
	input  gb_pkg::data_t irq_vec,
	input  gb_pkg::data_t wram_rdata,
	input  gb_pkg::data_t zpram_rdata,
	input  gb_pkg::data_t joy_rdata,
	input  gb_pkg::data_t sc_rdata,
	input  gb_pkg::data_t if_rdata,
	input  gb_pkg::data_t ie_rdata,
	input  gb_pkg::data_t svbk_rdata,
	input  gb_pkg::data_t cart_dout,
	output logic          wram_we,
	output logic          zpram_we,
	output logic          joy_we,
	output logic          sc_we,
	output logic          if_we,
	output logic          ie_we,
	output logic          svbk_we,
	output logic          cart_rd,
	output logic          cart_wr,
	output gb_pkg::data_t cpu_din
);

	gb_pkg::region_e region;
	logic            sel_cart;

	// ------------------------------------------------
	// region decode
	// ------------------------------------------------
	always_comb begin
		if (!cpu_addr[15]) begin
			region = gb_pkg::REG_ROM;                  // lower 32k
		end else if (cpu_addr[15:13] == 3'b101) begin
			region = gb_pkg::REG_CRAM;
		end else if (cpu_addr[15:14] == 2'b11 && cpu_addr[15:9] != 7'h7f) begin
			region = gb_pkg::REG_WRAM;                 // c000-fdff, echo folds in
		end else if (cpu_addr[15:7] == 9'h1ff && cpu_addr != `GB_ADDR_IE) begin
			region = gb_pkg::REG_ZPRAM;
		end else begin
			case (cpu_addr)
				`GB_ADDR_P1:   region = gb_pkg::REG_JOY;
				`GB_ADDR_SB:   region = gb_pkg::REG_SB;
				`GB_ADDR_SC:   region = gb_pkg::REG_SC;
				`GB_ADDR_IF:   region = gb_pkg::REG_IF;
				`GB_ADDR_SVBK: region = gb_pkg::REG_SVBK;
				`GB_ADDR_IE:   region = gb_pkg::REG_IE;
				default:       region = gb_pkg::REG_NONE;  // oam, io holes, vram
			endcase
		end
	end

	// write enables, one per writable target
	assign wram_we  = cpu_wr && region == gb_pkg::REG_WRAM;
	assign zpram_we = cpu_wr && region == gb_pkg::REG_ZPRAM;
	assign joy_we   = cpu_wr && region == gb_pkg::REG_JOY;
	assign sc_we    = cpu_wr && region == gb_pkg::REG_SC;
	assign if_we    = cpu_wr && region == gb_pkg::REG_IF;
	assign ie_we    = cpu_wr && region == gb_pkg::REG_IE;
	assign svbk_we  = cpu_wr && region == gb_pkg::REG_SVBK;

	// cartridge strobes, same cycle as the cpu
	assign sel_cart = region == gb_pkg::REG_ROM || region == gb_pkg::REG_CRAM;
	assign cart_rd  = cpu_rd && sel_cart;
	assign cart_wr  = cpu_wr && sel_cart;

	// ------------------------------------------------
	// read data, vector overrides everything
	// ------------------------------------------------
	always_comb begin
		if (cpu_ack) begin
			cpu_din = irq_vec;
		end else begin
			case (region)
				gb_pkg::REG_ROM,
				gb_pkg::REG_CRAM:  cpu_din = cart_dout;
				gb_pkg::REG_WRAM:  cpu_din = wram_rdata;   // one cycle late
				gb_pkg::REG_ZPRAM: cpu_din = zpram_rdata;
				gb_pkg::REG_JOY:   cpu_din = joy_rdata;
				gb_pkg::REG_SB:    cpu_din = `GB_OPEN_BUS; // no link partner
				gb_pkg::REG_SC:    cpu_din = sc_rdata;
				gb_pkg::REG_IF:    cpu_din = if_rdata;
				gb_pkg::REG_IE:    cpu_din = ie_rdata;
				gb_pkg::REG_SVBK:  cpu_din = svbk_rdata;
				default:           cpu_din = `GB_OPEN_BUS;
			endcase
		end
	end

endmodule

/* gb_wram.sv */
// ------------------------------------------------
// work ram with svbk banking, plus zero page ram
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_settings.svh"

module gb_wram (
	input  logic          clk_cpu,
	input  logic          reset,
	input  logic          is_gbc,
	input  gb_pkg::addr_t cpu_addr,
	input  gb_pkg::data_t cpu_dout,
	input  logic          wram_we,
	input  logic          zpram_we,
	input  logic          svbk_we,
	output gb_pkg::data_t wram_rdata,
	output gb_pkg::data_t zpram_rdata,
	output gb_pkg::data_t svbk_rdata
);

	logic [`GB_WRAM_BANK_W-1:0] svbk;       // 1-7
	logic [`GB_WRAM_BANK_W-1:0] bank;       // bank used by this access
	logic [`GB_WRAM_AW-1:0]     wram_addr;

	// ------------------------------------------------
	// svbk, only writable in colour mode
	// ------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			svbk <= `GB_WRAM_BANK_W'(1);
		end else if (svbk_we && is_gbc) begin
			if (cpu_dout[`GB_WRAM_BANK_W-1:0] == '0)
				svbk <= `GB_WRAM_BANK_W'(1);   // bank 0 maps to 1
			else
				svbk <= cpu_dout[`GB_WRAM_BANK_W-1:0];
		end
	end

	assign svbk_rdata = {{(`GB_DATA_W-`GB_WRAM_BANK_W){1'b1}}, svbk};

	// c000-cfff fixed bank 0, d000-dfff switchable
	assign bank      = cpu_addr[12] ? svbk : '0;
	assign wram_addr = {bank, cpu_addr[11:0]};

	gb_spram #(
		.addr_w (`GB_WRAM_AW)
	) i_wram (
		.clk_cpu (clk_cpu),
		.addr    (wram_addr),
		.we      (wram_we),
		.wdata   (cpu_dout),
		.rdata   (wram_rdata)
	);

	// ff80-fffe, low seven address bits
	gb_spram #(
		.addr_w (`GB_ZPRAM_AW)
	) i_zpram (
		.clk_cpu (clk_cpu),
		.addr    (cpu_addr[`GB_ZPRAM_AW-1:0]),
		.we      (zpram_we),
		.wdata   (cpu_dout),
		.rdata   (zpram_rdata)
	);

endmodule

/* gb_joypad.sv */
// ------------------------------------------------
// p1 joypad register and key press interrupt
// ------------------------------------------------
`timescale 1ns/10ps

module gb_joypad (
	input  logic          clk_cpu,
	input  logic          reset,
	input  logic [7:0]    joystick,   // start select b a down up left right
	input  gb_pkg::data_t cpu_dout,
	input  logic          joy_we,
	output gb_pkg::data_t joy_rdata,
	output logic          joy_irq
);

	logic [1:0] p54;                      // select, 0 enables group
	logic [3:0] joy_dir;
	logic [3:0] joy_btn;
	logic [7:0] line_d1;
	logic [7:0] line_d2;

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p54 <= 2'b00;
		else if (joy_we)
			p54 <= cpu_dout[5:4];
	end

	// active low lines, forced high when group not selected
	assign joy_dir = ~joystick[3:0] | {4{p54[0]}};
	assign joy_btn = ~joystick[7:4] | {4{p54[1]}};

	assign joy_rdata = {2'b11, p54, joy_dir & joy_btn};

	// two stage history of all gated lines
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			line_d1 <= '1;
			line_d2 <= '1;
		end else begin
			line_d1 <= {joy_btn, joy_dir};
			line_d2 <= line_d1;
		end
	end

	assign joy_irq = |(line_d2 & ~line_d1);   // any line fell

endmodule

/* gb_serial.sv */
// ------------------------------------------------
// dummy serial port, internal clock transfer with no partner
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_settings.svh"

module gb_serial (
	input  logic          clk_cpu,
	input  logic          reset,
	input  gb_pkg::data_t cpu_dout,
	input  logic          sc_we,
	output gb_pkg::data_t sc_rdata,
	output logic          serial_irq
);

	localparam int div_w = $clog2(`GB_SERIAL_DIV);
	localparam int cnt_w = $clog2(`GB_SERIAL_BITS + 1);

	logic             sc_start;       // sc bit 7
	logic             sc_clk;         // sc bit 0, internal clock
	logic [div_w-1:0] clk_div;        // cycles left in this bit
	logic [cnt_w-1:0] bit_cnt;        // bits left

	// ------------------------------------------------
	// transfer sequencer
	// ------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			clk_div    <= '0;
			bit_cnt    <= '0;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;                    // one cycle pulse
			if (sc_we) begin
				sc_start <= cpu_dout[7];
				sc_clk   <= cpu_dout[0];
				clk_div  <= div_w'(`GB_SERIAL_DIV - 1);
				bit_cnt  <= cnt_w'(`GB_SERIAL_BITS);
			end else if (sc_start && sc_clk) begin
				clk_div <= clk_div - 1'b1;
				if (clk_div == '0) begin          // bit period done
					clk_div <= div_w'(`GB_SERIAL_DIV - 1);
					if (bit_cnt == cnt_w'(1)) begin
						sc_start   <= 1'b0;         // transfer finished
						serial_irq <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
			end
			// external clock never ticks, transfer hangs
		end
	end

	assign sc_rdata = {sc_start, 6'h3f, sc_clk};

endmodule

/* gb_irq_ctrl.sv */
// ------------------------------------------------
// interrupt flags and enables, priority vector, acknowledge
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_settings.svh"

module gb_irq_ctrl (
	input  logic          clk_cpu,
	input  logic          reset,
	input  gb_pkg::data_t cpu_dout,
	input  logic          if_we,
	input  logic          ie_we,
	input  logic          cpu_ack,
	input  logic          vblank,       // level
	input  logic          lcd_irq,      // pulse
	input  logic          timer_irq,    // pulse
	input  logic          serial_irq,   // pulse
	input  logic          joy_irq,      // pulse
	output gb_pkg::data_t if_rdata,
	output gb_pkg::data_t ie_rdata,
	output gb_pkg::data_t irq_vec,
	output logic          irq
);

	gb_pkg::irq_t if_r;
	gb_pkg::irq_t ie_r;
	gb_pkg::irq_t pending;     // flagged and enabled
	gb_pkg::irq_t set;         // sources firing this cycle
	gb_pkg::irq_t clr;         // flag cleared by ack
	logic         vb_d1;
	logic         vb_d2;
	logic         ack_d;
	logic         ack_fall;

	// ------------------------------------------------
	// sources
	// ------------------------------------------------
	always_comb begin
		set                          = '0;
		set[gb_pkg::IRQ_VBLANK]      = vb_d1 & ~vb_d2;   // rising edge
		set[gb_pkg::IRQ_LCD]         = lcd_irq;
		set[gb_pkg::IRQ_TIMER]       = timer_irq;
		set[gb_pkg::IRQ_SERIAL]      = serial_irq;
		set[gb_pkg::IRQ_JOYPAD]      = joy_irq;
	end

	assign pending  = if_r & ie_r;
	assign ack_fall = ack_d & ~cpu_ack;

	// lowest set bit of pending is the winner
	assign clr = ack_fall ? (pending & (~pending + 1'b1)) : '0;

	// ------------------------------------------------
	// flag and enable registers
	// ------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			vb_d1 <= 1'b0;
			vb_d2 <= 1'b0;
			ack_d <= 1'b0;
			irq   <= 1'b0;
		end else begin
			vb_d1 <= vblank;
			vb_d2 <= vb_d1;
			ack_d <= cpu_ack;
			if (if_we)
				if_r <= cpu_dout[`GB_IRQ_N-1:0];   // cpu write wins
			else
				if_r <= (if_r | set) & ~clr;
			if (ie_we)
				ie_r <= cpu_dout[`GB_IRQ_N-1:0];
			irq <= |pending;                       // one cycle behind flags
		end
	end

	// unused upper bits read as ones
	assign if_rdata = {{(`GB_DATA_W-`GB_IRQ_N){1'b1}}, if_r};
	assign ie_rdata = {{(`GB_DATA_W-`GB_IRQ_N){1'b1}}, ie_r};

	// priority vector, scanned high to low so bit 0 ends on top
	always_comb begin
		irq_vec = `GB_IRQ_VEC_NONE;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pending[i])
				irq_vec = `GB_IRQ_VEC_BASE + gb_pkg::data_t'(`GB_IRQ_VEC_STEP * i);
		end
	end

endmodule

/* gb_sys.sv */
// ------------------------------------------------
// system bus top, cpu core and cartridge sit outside
// ------------------------------------------------
`timescale 1ns/10ps

module gb_sys (
	input  logic          clk_cpu,
	input  logic          reset,
	input  logic          is_gbc,
	input  gb_pkg::addr_t cpu_addr,
	input  gb_pkg::data_t cpu_dout,
	input  logic          cpu_rd,
	input  logic          cpu_wr,
	input  logic          cpu_ack,
	output gb_pkg::data_t cpu_din,
	output logic          irq,
	input  logic [7:0]    joystick,
	input  logic          vblank,
	input  logic          lcd_irq,
	input  logic          timer_irq,
	output gb_pkg::addr_t cart_addr,
	output gb_pkg::data_t cart_din,
	input  gb_pkg::data_t cart_dout,
	output logic          cart_rd,
	output logic          cart_wr
);

	// write enables from the decoder
	logic wram_we, zpram_we, joy_we, sc_we, if_we, ie_we, svbk_we;
	// read data back to the decoder
	gb_pkg::data_t wram_rdata, zpram_rdata, svbk_rdata;
	gb_pkg::data_t joy_rdata, sc_rdata, if_rdata, ie_rdata;
	gb_pkg::data_t irq_vec;
	logic          joy_irq;
	logic          serial_irq;

	// cartridge sees the raw cpu bus
	assign cart_addr = cpu_addr;
	assign cart_din  = cpu_dout;

	gb_bus_decode i_bus_decode (
		.cpu_addr (cpu_addr), .cpu_rd (cpu_rd), .cpu_wr (cpu_wr), .cpu_ack (cpu_ack),
		.irq_vec (irq_vec),
		.wram_rdata (wram_rdata), .zpram_rdata (zpram_rdata), .joy_rdata (joy_rdata),
		.sc_rdata (sc_rdata), .if_rdata (if_rdata), .ie_rdata (ie_rdata),
		.svbk_rdata (svbk_rdata), .cart_dout (cart_dout),
		.wram_we (wram_we), .zpram_we (zpram_we), .joy_we (joy_we), .sc_we (sc_we),
		.if_we (if_we), .ie_we (ie_we), .svbk_we (svbk_we),
		.cart_rd (cart_rd), .cart_wr (cart_wr), .cpu_din (cpu_din)
	);

	gb_wram i_wram (
		.clk_cpu (clk_cpu), .reset (reset), .is_gbc (is_gbc),
		.cpu_addr (cpu_addr), .cpu_dout (cpu_dout),
		.wram_we (wram_we), .zpram_we (zpram_we), .svbk_we (svbk_we),
		.wram_rdata (wram_rdata), .zpram_rdata (zpram_rdata), .svbk_rdata (svbk_rdata)
	);

	gb_joypad i_joypad (
		.clk_cpu (clk_cpu), .reset (reset), .joystick (joystick),
		.cpu_dout (cpu_dout), .joy_we (joy_we),
		.joy_rdata (joy_rdata), .joy_irq (joy_irq)
	);

	gb_serial i_serial (
		.clk_cpu (clk_cpu), .reset (reset), .cpu_dout (cpu_dout), .sc_we (sc_we),
		.sc_rdata (sc_rdata), .serial_irq (serial_irq)
	);

	// video and timer sources arrive as pins
	gb_irq_ctrl i_irq_ctrl (
		.clk_cpu (clk_cpu), .reset (reset), .cpu_dout (cpu_dout),
		.if_we (if_we), .ie_we (ie_we), .cpu_ack (cpu_ack),
		.vblank (vblank), .lcd_irq (lcd_irq), .timer_irq (timer_irq),
		.serial_irq (serial_irq), .joy_irq (joy_irq),
		.if_rdata (if_rdata), .ie_rdata (ie_rdata), .irq_vec (irq_vec), .irq (irq)
	);

endmodule

/* tb_gb_sys.sv */
// ------------------------------------------------
// directed testbench for the system bus top
// runs each test task in turn, stops at the first error
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_settings.svh"

module tb_gb_sys;

	localparam int clk_period   = 100;
	localparam int serial_wait  = `GB_SERIAL_BITS * `GB_SERIAL_DIV;   // cycles per transfer
	localparam int window       = 2;                                // serial timing margin
	localparam int limit_cycles = 2 * (serial_wait + 8) + 2000;     // both serial waits + rest

	logic          clk_cpu;
	logic          reset;
	logic          is_gbc;
	gb_pkg::addr_t cpu_addr;
	gb_pkg::data_t cpu_dout;
	logic          cpu_rd;
	logic          cpu_wr;
	logic          cpu_ack;
	gb_pkg::data_t cpu_din;
	logic          irq;
	logic [7:0]    joystick;
	logic          vblank;
	logic          lcd_irq;
	logic          timer_irq;
	gb_pkg::addr_t cart_addr;
	gb_pkg::data_t cart_din;
	gb_pkg::data_t cart_dout;
	logic          cart_rd;
	logic          cart_wr;
	logic [15:0]   lfsr = 16'd88;   // seed

	gb_sys i_gb_sys (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #(clk_period / 2) clk_cpu = ~clk_cpu;
	end

	initial begin
		#(limit_cycles * clk_period);
		report_fail("timeout, the tests did not finish in time");
	end

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	task automatic report_fail(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else report_fail($sformatf("MISMATCH time %0t %s expected %h actual %h",
			$time, name, expected, actual));
	endtask

	// fibonacci taps x^16 x^14 x^13 x^11 stepped once per bit
	function automatic logic [7:0] random_byte();
		logic [7:0] value;
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			value = {value[6:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic bus_write(input gb_pkg::addr_t addr, input gb_pkg::data_t data);
		@(negedge clk_cpu);
		cpu_addr = addr;
		cpu_dout = data;
		cpu_wr   = 1'b1;
		@(negedge clk_cpu);   // write landed on the edge between
		cpu_wr   = 1'b0;
	endtask

	task automatic bus_read(input gb_pkg::addr_t addr, output gb_pkg::data_t data);
		@(negedge clk_cpu);
		cpu_addr = addr;
		cpu_rd   = 1'b1;
		@(posedge clk_cpu);
		@(posedge clk_cpu);   // ram data valid after the first
		@(negedge clk_cpu);
		data     = cpu_din;
		cpu_rd   = 1'b0;
	endtask

	task automatic read_expect(input gb_pkg::addr_t addr, input gb_pkg::data_t expected,
		input string name);
		gb_pkg::data_t data;
		bus_read(addr, data);
		check_val(name, 16'(expected), 16'(data));
	endtask

	task automatic irq_ack(output gb_pkg::data_t vec);
		@(negedge clk_cpu);
		cpu_ack = 1'b1;
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		vec     = cpu_din;
		cpu_ack = 1'b0;       // flag clears on the next edge
	endtask

	task automatic wait_irq(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (irq !== level && n < max_cycles) begin
			@(negedge clk_cpu);
			n++;
		end
		assert (irq === level)
		else report_fail($sformatf("irq did not go to %b within %0d cycles", level, max_cycles));
	endtask

	// ------------------------------------------------
	// tests
	// ------------------------------------------------
	task automatic reset_values();
		check_val("irq", 16'h0, 16'(irq));
		check_val("cart_rd", 16'h0, 16'(cart_rd));
		check_val("cart_wr", 16'h0, 16'(cart_wr));
		read_expect(`GB_ADDR_IF, 8'he0, "if");      // unused bits read one
		read_expect(`GB_ADDR_IE, 8'he0, "ie");
		read_expect(`GB_ADDR_SVBK, 8'hf9, "svbk");  // bank 1
		read_expect(`GB_ADDR_SC, 8'h7e, "sc");
	endtask

	task automatic ram_banking();
		gb_pkg::data_t b0;
		gb_pkg::data_t b2;
		gb_pkg::data_t b5;
		gb_pkg::data_t z0;
		gb_pkg::data_t z1;
		b0 = random_byte();
		b2 = random_byte();
		while (b2 == b0)
			b2 = random_byte();
		b5 = random_byte();
		while (b5 == b0 || b5 == b2)
			b5 = random_byte();
		bus_write(`GB_ADDR_SVBK, 8'h02);
		bus_write(16'hd123, b2);
		bus_write(`GB_ADDR_SVBK, 8'h05);
		bus_write(16'hd123, b5);
		bus_write(16'hc123, b0);                    // fixed bank 0
		read_expect(16'hd123, b5, "wram d123 bank 5");
		read_expect(16'hc123, b0, "wram c123 bank 0");
		bus_write(`GB_ADDR_SVBK, 8'h02);
		read_expect(16'hd123, b2, "wram d123 bank 2");
		read_expect(16'hf123, b2, "echo f123 bank 2");
		bus_write(`GB_ADDR_SVBK, 8'h00);            // 0 selects bank 1
		read_expect(`GB_ADDR_SVBK, 8'hf9, "svbk after 0");
		z0 = random_byte();
		z1 = random_byte();
		bus_write(16'hff80, z0);
		bus_write(16'hfffe, z1);
		read_expect(16'hff80, z0, "zpram ff80");
		read_expect(16'hfffe, z1, "zpram fffe");
		// monochrome ignores svbk
		is_gbc = 1'b0;
		bus_write(`GB_ADDR_SVBK, 8'h06);
		read_expect(`GB_ADDR_SVBK, 8'hf9, "svbk in mono mode");
		is_gbc = 1'b1;
	endtask

	task automatic joypad_matrix();
		logic [1:0]    sel;
		logic [3:0]    dir;
		logic [3:0]    btn;
		gb_pkg::data_t if_set;
		for (int s = 0; s < 4; s++) begin
			sel = 2'(s);
			bus_write(`GB_ADDR_P1, {2'b00, sel, 4'h0});
			for (int k = 0; k < 4; k++) begin
				joystick = random_byte();
				dir = sel[0] ? 4'hf : ~joystick[3:0];   // select 0 enables group
				btn = sel[1] ? 4'hf : ~joystick[7:4];
				read_expect(`GB_ADDR_P1, {2'b11, sel, dir & btn}, "p1");
			end
		end
		// buttons only, nothing pressed, then press start
		joystick = 8'h00;
		bus_write(`GB_ADDR_P1, 8'h10);
		bus_write(`GB_ADDR_IF, 8'h00);
		bus_write(`GB_ADDR_IE, 8'h10);
		joystick = 8'h80;
		wait_irq(1'b1, 6);
		if_set = 8'he0 | (8'h01 << gb_pkg::IRQ_JOYPAD);
		read_expect(`GB_ADDR_IF, if_set, "if joypad");
		bus_write(`GB_ADDR_IE, 8'h00);
		bus_write(`GB_ADDR_IF, 8'h00);
	endtask

	task automatic irq_priority();
		gb_pkg::data_t vec;
		bus_write(`GB_ADDR_IF, 8'h00);
		timer_irq = 1'b1;                           // one cycle pulses
		@(negedge clk_cpu);
		timer_irq = 1'b0;
		lcd_irq   = 1'b1;
		@(negedge clk_cpu);
		lcd_irq   = 1'b0;
		bus_write(`GB_ADDR_IE, 8'h1f);
		wait_irq(1'b1, 4);
		irq_ack(vec);
		check_val("vector lcd", 16'h0048, 16'(vec));
		irq_ack(vec);
		check_val("vector timer", 16'h0050, 16'(vec));
		wait_irq(1'b0, 4);
		vblank = 1'b1;                              // level held high
		wait_irq(1'b1, 6);
		irq_ack(vec);
		check_val("vector vblank", 16'h0040, 16'(vec));
		vblank = 1'b0;
		bus_write(`GB_ADDR_IE, 8'h00);
		bus_write(`GB_ADDR_IF, 8'h1f);              // all flagged, none enabled
		wait_irq(1'b0, 4);
		irq_ack(vec);
		check_val("vector none", 16'h0055, 16'(vec));
	endtask

	task automatic serial_transfer();
		int n;
		bus_write(`GB_ADDR_IF, 8'h00);
		bus_write(`GB_ADDR_IE, 8'h08);              // serial only
		cpu_addr = `GB_ADDR_SC;
		cpu_dout = 8'h81;                           // start, internal clock
		cpu_wr   = 1'b1;
		@(negedge clk_cpu);
		cpu_wr   = 1'b0;
		n = 0;                                      // edges since the sc write
		while (irq !== 1'b1 && n < serial_wait + window + 1) begin
			@(negedge clk_cpu);
			n++;
		end
		// irq trails the flag by one edge
		assert (irq === 1'b1 && n >= serial_wait - window + 1)
		else report_fail($sformatf("serial interrupt outside window, %0d cycles, expected %0d",
			n, serial_wait + 1));
		read_expect(`GB_ADDR_IF, 8'he8, "if serial");
		read_expect(`GB_ADDR_SC, 8'h7f, "sc after transfer");
		read_expect(`GB_ADDR_SB, 8'hff, "sb");
		// external clock never ends
		bus_write(`GB_ADDR_IF, 8'h00);
		bus_write(`GB_ADDR_SC, 8'h80);
		repeat (serial_wait + window + 2) begin
			@(negedge clk_cpu);
			check_val("irq with sc 80", 16'h0, 16'(irq));
		end
		read_expect(`GB_ADDR_IF, 8'he0, "if no serial");
		read_expect(`GB_ADDR_SC, 8'hfe, "sc still busy");
		bus_write(`GB_ADDR_SC, 8'h00);
		bus_write(`GB_ADDR_IE, 8'h00);
	endtask

	task automatic cart_passthrough();
		gb_pkg::data_t d;
		d         = random_byte();
		cart_dout = d;
		cpu_addr  = 16'h1234;
		cpu_rd    = 1'b1;
		@(negedge clk_cpu);
		check_val("cart_addr", 16'h1234, cart_addr);
		check_val("cart_rd", 16'h1, 16'(cart_rd));
		check_val("cpu_din rom", 16'(d), 16'(cpu_din));
		cpu_rd    = 1'b0;
		d         = random_byte();
		cpu_addr  = 16'ha000;
		cpu_dout  = d;
		cpu_wr    = 1'b1;
		@(negedge clk_cpu);
		check_val("cart_wr", 16'h1, 16'(cart_wr));
		check_val("cart_din", 16'(d), 16'(cart_din));
		cpu_wr    = 1'b0;
		cpu_addr  = 16'hc000;                       // wram, not cartridge
		cpu_rd    = 1'b1;
		@(negedge clk_cpu);
		check_val("cart_rd at c000", 16'h0, 16'(cart_rd));
		check_val("cart_wr at c000", 16'h0, 16'(cart_wr));
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b1;
		@(negedge clk_cpu);
		check_val("cart_rd at c000 write", 16'h0, 16'(cart_rd));
		check_val("cart_wr at c000 write", 16'h0, 16'(cart_wr));
		cpu_wr    = 1'b0;
	endtask

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin
		reset     = 1'b1;
		is_gbc    = 1'b1;   // colour mode
		cpu_addr  = '0;
		cpu_dout  = '0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cpu_ack   = 1'b0;
		joystick  = '0;
		vblank    = 1'b0;
		lcd_irq   = 1'b0;
		timer_irq = 1'b0;
		cart_dout = '0;
		repeat (8) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset     = 1'b0;
		reset_values();
		ram_banking();
		joypad_matrix();
		irq_priority();
		serial_transfer();
		cart_passthrough();
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* files.f */
+incdir+.
gb_pkg.sv
gb_spram.sv
gb_bus_decode.sv
gb_wram.sv
gb_joypad.sv
gb_serial.sv
gb_irq_ctrl.sv
gb_sys.sv
tb_gb_sys.sv

/* Makefile */
# Verilator lint, simulation and cleanup for the system bus project
TB  = tb_gb_sys
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module gb_sys
	verilator --lint-only --timing -f files.f --top-module $(TB)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TB) -o $(TB)
	./obj_dir/$(TB) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
